//--- lcd_pkg.sv
package lcd_pkg;

    // --------------------------------------------------------------------------
    // bundles
    // --------------------------------------------------------------------------

    // one init table entry, is_data is bit 8 of the hex word
    typedef struct packed {
        logic       is_data;
        logic [7:0] value;
    } init_entry_t;

    typedef struct packed {
        logic       valid;
        logic       is_data;
        logic [7:0] value;
    } spi_byte_t;

    typedef struct packed {
        logic panel_resetn;
        logic cs;
        logic dc;
        logic sda;
    } lcd_pins_t;

    typedef struct packed {
        logic [7:0] glyph_code;
        logic [2:0] row;
        logic [3:0] column;
    } print_cmd_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // --------------------------------------------------------------------------
    // panel commands and geometry
    // --------------------------------------------------------------------------
    localparam int INIT_LEN = 70;

    localparam logic [7:0] CMD_SLEEP_OUT    = 8'h11;
    localparam logic [7:0] CMD_COLUMN_SET   = 8'h2A;
    localparam logic [7:0] CMD_ROW_SET      = 8'h2B;
    localparam logic [7:0] CMD_MEMORY_WRITE = 8'h2C;

    localparam int CELL_SIZE   = 8;
    localparam int CELL_PIXELS = 64;

    // visible area starts here on the 135x240 glass
    localparam logic [15:0] X_OFFSET = 16'd40;
    localparam logic [15:0] Y_OFFSET = 16'd52;

    localparam logic [15:0] COLOR_FG = 16'hFFFF;
    localparam logic [15:0] COLOR_BG = 16'h0000;

    // delays at 27 MHz
    localparam logic [31:0] DEF_RESET_CYCLES   = 32'd2_700_000;
    localparam logic [31:0] DEF_PREPARE_CYCLES = 32'd5_400_000;
    localparam logic [31:0] DEF_SNOOZE_CYCLES  = 32'd3_240_000;

    // register map
    localparam logic [1:0] ADR_PRINT  = 2'd0;
    localparam logic [1:0] ADR_STATUS = 2'd1;

endpackage

//--- lcd_spi_tx.sv
`timescale 1ns/1ps

module lcd_spi_tx (
    input  logic               clk,
    input  logic               resetn,
    input  lcd_pkg::spi_byte_t tx_req,
    output logic               tx_ready,
    output logic               cs,
    output logic               dc,
    output logic               sda,
    output logic               sck
);

    logic [7:0] shreg;
    logic [2:0] bit_cnt;
    // byte captured, cs still high for the gap cycle
    logic       loaded;

    // ready when idle, or while the last bit of a byte is on the wire
    assign tx_ready = !loaded && (cs || bit_cnt == 3'd7);

    assign sda = shreg[7];
    // panel samples on the falling edge of clk
    assign sck = ~clk;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cs      <= 1'b1;
            dc      <= 1'b1;
            shreg   <= 8'hFF;
            bit_cnt <= 3'd0;
            loaded  <= 1'b0;
        end else if (tx_req.valid && tx_ready) begin
            shreg   <= tx_req.value;
            dc      <= tx_req.is_data;
            cs      <= 1'b1;
            bit_cnt <= 3'd0;
            loaded  <= 1'b1;
        end else if (loaded) begin
            cs     <= 1'b0;
            loaded <= 1'b0;
        end else if (!cs) begin
            // ones fill in behind the data, so sda idles high
            shreg   <= {shreg[6:0], 1'b1};
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                cs <= 1'b1;
                dc <= 1'b1;
            end
        end
    end

endmodule

//--- lcd_font.sv
`timescale 1ns/1ps

module lcd_font (
    input  logic [7:0]  glyph_code,
    input  logic [5:0]  pixel_index,
    input  logic [3:0]  column,
    input  logic [2:0]  row,
    output logic [15:0] pixel,
    output logic [15:0] x_start,
    output logic [15:0] x_end,
    output logic [15:0] y_start,
    output logic [15:0] y_end
);

    // ten digits, one byte per glyph row, bit 7 leftmost
    logic [7:0] glyph_rom [10 * lcd_pkg::CELL_SIZE];
    logic       is_digit;
    logic [6:0] rom_addr;
    logic [7:0] glyph_row;

    initial begin
        $readmemh("font.hex", glyph_rom);
    end

    assign is_digit = (glyph_code >= 8'h30) && (glyph_code <= 8'h39);

    // low nibble of an ascii digit is the digit itself
    assign rom_addr  = is_digit ? {glyph_code[3:0], pixel_index[5:3]} : 7'd0;
    assign glyph_row = glyph_rom[rom_addr];

    assign pixel = (is_digit && glyph_row[3'd7 - pixel_index[2:0]]) ?
                   lcd_pkg::COLOR_FG : lcd_pkg::COLOR_BG;

    // cell window in panel coordinates
    assign x_start = lcd_pkg::X_OFFSET + 16'(column) * 16'(lcd_pkg::CELL_SIZE);
    assign x_end   = x_start + 16'(lcd_pkg::CELL_SIZE - 1);
    assign y_start = lcd_pkg::Y_OFFSET + 16'(row) * 16'(lcd_pkg::CELL_SIZE);
    assign y_end   = y_start + 16'(lcd_pkg::CELL_SIZE - 1);

endmodule

//--- lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer #(
    parameter logic [31:0] RESET_CYCLES   = lcd_pkg::DEF_RESET_CYCLES,
    parameter logic [31:0] PREPARE_CYCLES = lcd_pkg::DEF_PREPARE_CYCLES,
    parameter logic [31:0] SNOOZE_CYCLES  = lcd_pkg::DEF_SNOOZE_CYCLES
) (
    input  logic                clk,
    input  logic                resetn,
    input  lcd_pkg::print_cmd_t cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    output logic                busy,
    output logic                init_done,
    output lcd_pkg::spi_byte_t  tx_req,
    input  logic                tx_ready,
    output logic                panel_resetn,
    output logic [7:0]          glyph_code,
    output logic [5:0]          pixel_index,
    output logic [3:0]          column,
    output logic [2:0]          row,
    input  logic [15:0]         pixel,
    input  logic [15:0]         x_start,
    input  logic [15:0]         x_end,
    input  logic [15:0]         y_start,
    input  logic [15:0]         y_end
);

    localparam int WIN_BYTES = 11;

    typedef enum logic [3:0] {
        ST_RESET, ST_PREPARE, ST_WAKEUP, ST_SNOOZE, ST_TABLE,
        ST_DRAIN, ST_IDLE, ST_WINDOW, ST_PIXEL
    } state_t;

    state_t               state;
    logic [31:0]          delay_cnt;
    // shared by table walk, window bytes and pixel bytes
    logic [7:0]           byte_idx;
    lcd_pkg::print_cmd_t  cmd_q;
    logic [8:0]           init_rom [lcd_pkg::INIT_LEN];
    lcd_pkg::init_entry_t entry;
    lcd_pkg::spi_byte_t   win_byte;
    logic                 slot_free;

    initial begin
        $readmemh("init_table.hex", init_rom);
    end

    assign entry     = lcd_pkg::init_entry_t'(init_rom[byte_idx[6:0]]);
    assign slot_free = !tx_req.valid || tx_ready;
    assign cmd_ready = (state == ST_IDLE);

    assign glyph_code  = cmd_q.glyph_code;
    assign column      = cmd_q.column;
    assign row         = cmd_q.row;
    // two bytes per pixel
    assign pixel_index = byte_idx[6:1];

    // --------------------------------------------------------------------------
    // window setup bytes, high byte first
    // --------------------------------------------------------------------------
    always_comb begin
        win_byte = '{valid: 1'b1, is_data: 1'b1, value: 8'h00};
        case (byte_idx[3:0])
            4'd0: begin
                win_byte.is_data = 1'b0;
                win_byte.value   = lcd_pkg::CMD_COLUMN_SET;
            end
            4'd1:    win_byte.value = x_start[15:8];
            4'd2:    win_byte.value = x_start[7:0];
            4'd3:    win_byte.value = x_end[15:8];
            4'd4:    win_byte.value = x_end[7:0];
            4'd5: begin
                win_byte.is_data = 1'b0;
                win_byte.value   = lcd_pkg::CMD_ROW_SET;
            end
            4'd6:    win_byte.value = y_start[15:8];
            4'd7:    win_byte.value = y_start[7:0];
            4'd8:    win_byte.value = y_end[15:8];
            4'd9:    win_byte.value = y_end[7:0];
            4'd10: begin
                win_byte.is_data = 1'b0;
                win_byte.value   = lcd_pkg::CMD_MEMORY_WRITE;
            end
            default: win_byte.value = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
    end

    // --------------------------------------------------------------------------
    // main FSM
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state        <= ST_RESET;
            delay_cnt    <= 32'd0;
            byte_idx     <= 8'd0;
            tx_req       <= '0;
            panel_resetn <= 1'b0;
            init_done    <= 1'b0;
            busy         <= 1'b0;
        end else begin
            case (state)
                ST_RESET: begin
                    if (delay_cnt == RESET_CYCLES) begin
                        delay_cnt    <= 32'd0;
                        panel_resetn <= 1'b1;
                        state        <= ST_PREPARE;
                    end else begin
                        delay_cnt <= delay_cnt + 32'd1;
                    end
                end
                ST_PREPARE: begin
                    if (delay_cnt == PREPARE_CYCLES) begin
                        delay_cnt <= 32'd0;
                        state     <= ST_WAKEUP;
                    end else begin
                        delay_cnt <= delay_cnt + 32'd1;
                    end
                end
                ST_WAKEUP: begin
                    if (!tx_req.valid) begin
                        tx_req <= '{valid: 1'b1, is_data: 1'b0,
                                    value: lcd_pkg::CMD_SLEEP_OUT};
                    end else if (tx_ready) begin
                        tx_req.valid <= 1'b0;
                        state        <= ST_SNOOZE;
                    end
                end
                ST_SNOOZE: begin
                    if (delay_cnt == SNOOZE_CYCLES) begin
                        delay_cnt <= 32'd0;
                        byte_idx  <= 8'd0;
                        state     <= ST_TABLE;
                    end else begin
                        delay_cnt <= delay_cnt + 32'd1;
                    end
                end
                ST_TABLE: begin
                    if (slot_free) begin
                        if (byte_idx == 8'(lcd_pkg::INIT_LEN)) begin
                            tx_req.valid <= 1'b0;
                            state        <= ST_DRAIN;
                        end else begin
                            tx_req   <= '{valid: 1'b1, is_data: entry.is_data,
                                          value: entry.value};
                            byte_idx <= byte_idx + 8'd1;
                        end
                    end
                end
                // last byte leaves the serialiser when ready comes back
                ST_DRAIN: begin
                    if (tx_ready) begin
                        init_done <= 1'b1;
                        busy      <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (cmd_valid) begin
                        busy     <= 1'b1;
                        byte_idx <= 8'd0;
                        state    <= ST_WINDOW;
                    end
                end
                ST_WINDOW: begin
                    if (slot_free) begin
                        if (byte_idx == 8'(WIN_BYTES)) begin
                            tx_req.valid <= 1'b0;
                            byte_idx     <= 8'd0;
                            state        <= ST_PIXEL;
                        end else begin
                            tx_req   <= win_byte;
                            byte_idx <= byte_idx + 8'd1;
                        end
                    end
                end
                ST_PIXEL: begin
                    if (slot_free) begin
                        if (byte_idx == 8'(2 * lcd_pkg::CELL_PIXELS)) begin
                            tx_req.valid <= 1'b0;
                            state        <= ST_DRAIN;
                        end else begin
                            tx_req   <= '{valid: 1'b1, is_data: 1'b1,
                                          value: byte_idx[0] ? pixel[7:0] : pixel[15:8]};
                            byte_idx <= byte_idx + 8'd1;
                        end
                    end
                end
                default: state <= ST_RESET;
            endcase
        end
    end

endmodule

//--- lcd_wb_regs.sv
`timescale 1ns/1ps

module lcd_wb_regs (
    input  logic                clk,
    input  logic                resetn,
    input  lcd_pkg::wb_req_t    wb_in,
    output lcd_pkg::wb_rsp_t    wb_out,
    output lcd_pkg::print_cmd_t cmd,
    output logic                cmd_valid,
    input  logic                cmd_ready,
    input  logic                busy,
    input  logic                init_done
);

    logic        cyc_open;
    logic        print_wr;
    logic        ack_q;
    logic [31:0] rd_dat_q;

    assign cyc_open = wb_in.cyc && wb_in.stb;
    assign print_wr = cyc_open && wb_in.we && (wb_in.adr == lcd_pkg::ADR_PRINT);

    // print write goes straight to the sequencer, ack is the handshake
    assign cmd_valid = print_wr;
    assign cmd = '{glyph_code: wb_in.dat[15:8],
                   row:        wb_in.dat[6:4],
                   column:     wb_in.dat[3:0]};

    // everything else gets a one cycle ack pulse
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= cyc_open && !print_wr && !ack_q;
        end
    end

    // status read, zero for any other access
    always_ff @(posedge clk) begin
        if (cyc_open && !wb_in.we && wb_in.adr == lcd_pkg::ADR_STATUS) begin
            rd_dat_q <= {30'd0, busy, init_done};
        end else begin
            rd_dat_q <= 32'd0;
        end
    end

    assign wb_out = '{ack: ack_q || (print_wr && cmd_ready), dat: rd_dat_q};

endmodule

//--- lcd_top.sv
`timescale 1ns/1ps

module lcd_top #(
    parameter logic [31:0] RESET_CYCLES   = lcd_pkg::DEF_RESET_CYCLES,
    parameter logic [31:0] PREPARE_CYCLES = lcd_pkg::DEF_PREPARE_CYCLES,
    parameter logic [31:0] SNOOZE_CYCLES  = lcd_pkg::DEF_SNOOZE_CYCLES
) (
    input  logic               clk,
    input  logic               resetn,
    input  lcd_pkg::wb_req_t   wb_in,
    output lcd_pkg::wb_rsp_t   wb_out,
    output lcd_pkg::lcd_pins_t pins,
    output logic               sck
);

    lcd_pkg::print_cmd_t cmd;
    logic                cmd_valid;
    logic                cmd_ready;
    logic                busy;
    logic                init_done;
    lcd_pkg::spi_byte_t  tx_req;
    logic                tx_ready;
    logic                panel_resetn;
    logic                spi_cs;
    logic                spi_dc;
    logic                spi_sda;
    logic [7:0]          glyph_code;
    logic [5:0]          pixel_index;
    logic [3:0]          column;
    logic [2:0]          row;
    logic [15:0]         pixel;
    logic [15:0]         x_start;
    logic [15:0]         x_end;
    logic [15:0]         y_start;
    logic [15:0]         y_end;

    assign pins = '{panel_resetn: panel_resetn, cs: spi_cs, dc: spi_dc, sda: spi_sda};

    lcd_wb_regs u_wb_regs (
        .clk       (clk),
        .resetn    (resetn),
        .wb_in     (wb_in),
        .wb_out    (wb_out),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .busy      (busy),
        .init_done (init_done)
    );

    lcd_sequencer #(
        .RESET_CYCLES   (RESET_CYCLES),
        .PREPARE_CYCLES (PREPARE_CYCLES),
        .SNOOZE_CYCLES  (SNOOZE_CYCLES)
    ) u_sequencer (
        .clk          (clk),
        .resetn       (resetn),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .busy         (busy),
        .init_done    (init_done),
        .tx_req       (tx_req),
        .tx_ready     (tx_ready),
        .panel_resetn (panel_resetn),
        .glyph_code   (glyph_code),
        .pixel_index  (pixel_index),
        .column       (column),
        .row          (row),
        .pixel        (pixel),
        .x_start      (x_start),
        .x_end        (x_end),
        .y_start      (y_start),
        .y_end        (y_end)
    );

    lcd_font u_font (
        .glyph_code  (glyph_code),
        .pixel_index (pixel_index),
        .column      (column),
        .row         (row),
        .pixel       (pixel),
        .x_start     (x_start),
        .x_end       (x_end),
        .y_start     (y_start),
        .y_end       (y_end)
    );

    lcd_spi_tx u_spi_tx (
        .clk      (clk),
        .resetn   (resetn),
        .tx_req   (tx_req),
        .tx_ready (tx_ready),
        .cs       (spi_cs),
        .dc       (spi_dc),
        .sda      (spi_sda),
        .sck      (sck)
    );

endmodule

//--- tb_lcd.sv
`timescale 1ns/1ps

module tb_lcd;

    localparam int RESET_DLY   = 20;
    localparam int PREPARE_DLY = 30;
    localparam int SNOOZE_DLY  = 25;
    localparam int DRAW_BYTES  = 139;
    localparam int NUM_DRAWS   = 6;
    // letter code on this draw gives a blank cell
    localparam int BLANK_DRAW  = 3;
    localparam int TOTAL_BYTES = 1 + lcd_pkg::INIT_LEN + NUM_DRAWS * DRAW_BYTES;
    localparam int CYCLE_LIMIT = 2 * (RESET_DLY + PREPARE_DLY + SNOOZE_DLY) + 9 * TOTAL_BYTES;

    logic               clk;
    logic               resetn;
    lcd_pkg::wb_req_t   wb_in;
    lcd_pkg::wb_rsp_t   wb_out;
    lcd_pkg::lcd_pins_t pins;
    logic               sck;

    logic [8:0] init_mem [lcd_pkg::INIT_LEN];
    logic [7:0] font_mem [80];
    logic [8:0] exp_q [$];
    logic [8:0] rx_q [$];
    logic [7:0] shift_byte;
    logic       byte_dc;
    int         bit_count;
    int         rx_count;
    int         compared;
    int         error_count;

    lcd_top #(
        .RESET_CYCLES   (RESET_DLY),
        .PREPARE_CYCLES (PREPARE_DLY),
        .SNOOZE_CYCLES  (SNOOZE_DLY)
    ) DUT (
        .clk    (clk),
        .resetn (resetn),
        .wb_in  (wb_in),
        .wb_out (wb_out),
        .pins   (pins),
        .sck    (sck)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // checking and reference model
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0d ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // byte k of a draw as {dc, value}
    function automatic logic [8:0] draw_byte(input logic [7:0] code, input logic [2:0] r,
                                             input logic [3:0] c, input int k);
        logic [15:0] xs;
        logic [15:0] xe;
        logic [15:0] ys;
        logic [15:0] ye;
        logic [15:0] color;
        logic [7:0]  glyph;
        logic [6:0]  rom_idx;
        logic [2:0]  bit_sel;
        logic [8:0]  result;
        int          p;
        xs = lcd_pkg::X_OFFSET + 16'(c) * 16'(lcd_pkg::CELL_SIZE);
        xe = xs + 16'(lcd_pkg::CELL_SIZE - 1);
        ys = lcd_pkg::Y_OFFSET + 16'(r) * 16'(lcd_pkg::CELL_SIZE);
        ye = ys + 16'(lcd_pkg::CELL_SIZE - 1);
        p  = (k - 11) / 2;
        case (k)
            0:  result = {1'b0, lcd_pkg::CMD_COLUMN_SET};
            1:  result = {1'b1, xs[15:8]};
            2:  result = {1'b1, xs[7:0]};
            3:  result = {1'b1, xe[15:8]};
            4:  result = {1'b1, xe[7:0]};
            5:  result = {1'b0, lcd_pkg::CMD_ROW_SET};
            6:  result = {1'b1, ys[15:8]};
            7:  result = {1'b1, ys[7:0]};
            8:  result = {1'b1, ye[15:8]};
            9:  result = {1'b1, ye[7:0]};
            10: result = {1'b0, lcd_pkg::CMD_MEMORY_WRITE};
            default: begin
                glyph = 8'h00;
                if (code >= 8'h30 && code <= 8'h39) begin
                    rom_idx = 7'((int'(code) - 48) * 8 + p / 8);
                    glyph   = font_mem[rom_idx];
                end
                bit_sel = 3'(7 - p % 8);
                color   = glyph[bit_sel] ? lcd_pkg::COLOR_FG : lcd_pkg::COLOR_BG;
                // high byte of each pixel first
                if ((k - 11) % 2 == 0) begin
                    result = {1'b1, color[15:8]};
                end else begin
                    result = {1'b1, color[7:0]};
                end
            end
        endcase
        return result;
    endfunction

    function automatic void schedule_draw(input logic [7:0] code, input logic [2:0] r,
                                          input logic [3:0] c);
        for (int k = 0; k < DRAW_BYTES; k++) begin
            exp_q.push_back(draw_byte(code, r, c, k));
        end
    endfunction

    // ----------------------------------------------------------------------
    // wishbone host
    // ----------------------------------------------------------------------
    task automatic write_bus(input logic [1:0] adr, input logic [31:0] dat,
                             output int bytes_at_ack);
        @(posedge clk);
        #2;
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        @(negedge clk);
        while (!wb_out.ack) begin
            @(negedge clk);
        end
        bytes_at_ack = rx_count;
        @(posedge clk);
        #2;
        wb_in = '0;
    endtask

    task automatic read_bus(input logic [1:0] adr, output logic [31:0] dat);
        @(posedge clk);
        #2;
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0};
        @(negedge clk);
        while (!wb_out.ack) begin
            @(negedge clk);
        end
        dat = wb_out.dat;
        @(posedge clk);
        #2;
        wb_in = '0;
    endtask

    // ----------------------------------------------------------------------
    // pin monitor samples sda on the falling edge like the panel
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (pins.cs === 1'b0) begin
            check_value("pins.panel_resetn", 32'(pins.panel_resetn), 32'd1);
            if (bit_count == 0) begin
                byte_dc = pins.dc;
            end else begin
                check_value("pins.dc", 32'(pins.dc), 32'(byte_dc));
            end
            shift_byte = {shift_byte[6:0], pins.sda};
            bit_count  = bit_count + 1;
            if (bit_count == 8) begin
                rx_q.push_back({byte_dc, shift_byte});
                rx_count  = rx_count + 1;
                bit_count = 0;
            end
        end
    end

    // panel clock is low while clk is high and high while clk is low
    initial begin : sck_watch
        forever begin
            @(posedge clk);
            #1;
            check_value("sck", 32'(sck), 32'd0);
            @(negedge clk);
            #1;
            check_value("sck", 32'(sck), 32'd1);
        end
    end

    initial begin : compare_bytes
        logic [8:0] got;
        compared = 0;
        forever begin
            @(posedge clk);
            while (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                if (compared >= exp_q.size()) begin
                    $display("unexpected byte 0x%0h on the panel bus at %0d ns",
                             got[7:0], $time);
                    $display("SIMULATION FAILED");
                    $fatal(1, "extra byte");
                end
                check_value($sformatf("byte %0d dc", compared),
                            32'(got[8]), 32'(exp_q[compared][8]));
                check_value($sformatf("byte %0d value", compared),
                            32'(got[7:0]), 32'(exp_q[compared][7:0]));
                compared++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("timeout after %0d cycles, %0d of %0d bytes seen",
                         cycles, compared, exp_q.size());
                $display("SIMULATION FAILED");
                $fatal(1, "cycle limit reached");
            end
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin : main_seq
        logic [31:0] rd;
        logic [7:0]  code;
        logic [2:0]  r;
        logic [3:0]  c;
        int          at_ack;
        int          expected_before;
        void'($urandom(13));
        resetn      = 1'b0;
        wb_in       = '0;
        shift_byte  = 8'h00;
        byte_dc     = 1'b1;
        bit_count   = 0;
        rx_count    = 0;
        error_count = 0;
        $readmemh("init_table.hex", init_mem);
        $readmemh("font.hex", font_mem);

        // power-up stream is sleep-out then the table
        exp_q.push_back({1'b0, lcd_pkg::CMD_SLEEP_OUT});
        for (int i = 0; i < lcd_pkg::INIT_LEN; i++) begin
            exp_q.push_back(init_mem[7'(i)]);
        end

        repeat (5) begin
            @(posedge clk);
            #2;
            check_value("pins.cs", 32'(pins.cs), 32'd1);
            check_value("pins.panel_resetn", 32'(pins.panel_resetn), 32'd0);
            check_value("wb_out.ack", 32'(wb_out.ack), 32'd0);
        end
        resetn = 1'b1;
        @(negedge clk);
        check_value("pins.cs", 32'(pins.cs), 32'd1);
        check_value("pins.panel_resetn", 32'(pins.panel_resetn), 32'd0);
        read_bus(lcd_pkg::ADR_STATUS, rd);
        check_value("status after reset", rd, 32'd0);

        // first write lands during power-up and later ones during a draw
        for (int n = 0; n < NUM_DRAWS; n++) begin
            if (n == BLANK_DRAW) begin
                code = 8'h41 + 8'($urandom % 26);
            end else begin
                code = 8'h30 + 8'($urandom % 10);
            end
            r = 3'($urandom);
            c = 4'($urandom);
            expected_before = exp_q.size();
            schedule_draw(code, r, c);
            write_bus(lcd_pkg::ADR_PRINT, {16'd0, code, 1'b0, r, c}, at_ack);
            check_value("bytes sent before print ack", at_ack, expected_before);
            read_bus(lcd_pkg::ADR_STATUS, rd);
            check_value("status during draw", rd, 32'd3);
        end

        while (compared < exp_q.size()) begin
            @(posedge clk);
        end
        read_bus(lcd_pkg::ADR_STATUS, rd);
        check_value("status after last draw", rd, 32'd1);

        if (error_count == 0 && rx_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

//--- init_table.hex
// bit 8 is the dc flag, 1 for data and 0 for command
// bits 7:0 are the byte sent to the panel
036
100
03A
105
0B2
10C
10C
100
133
133
0B7
135
0BB
119
0C0
12C
0C2
101
0C3
112
0C4
120
0C6
10F
0D0
1A4
1A1
0E0
1D0
104
10D
111
113
12B
13F
154
14C
118
10D
10B
11F
123
0E1
1D0
104
10C
111
113
12C
13F
144
151
12F
11F
11F
120
123
02A
100
128
101
117
02B
100
135
100
1BB
021
013
029

//--- font.hex
// digit glyphs '0' to '9', eight rows each, top row first
// one byte per row, bit 7 is the leftmost pixel
3C
66
6E
76
66
66
3C
00
18
38
18
18
18
18
7E
00
3C
66
06
0C
30
60
7E
00
3C
66
06
1C
06
66
3C
00
0C
1C
3C
6C
7E
0C
0C
00
7E
60
7C
06
06
66
3C
00
3C
60
7C
66
66
66
3C
00
7E
06
0C
18
30
30
30
00
3C
66
66
3C
66
66
3C
00
3C
66
66
3E
06
0C
38
00

//--- project.f
lcd_pkg.sv
lcd_spi_tx.sv
lcd_font.sv
lcd_sequencer.sv
lcd_wb_regs.sv
lcd_top.sv
tb_lcd.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_lcd
RTL_TOP   ?= lcd_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
SOURCES   := $(shell cat $(FILELIST))
DATA      ?= init_table.hex font.hex

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP) $(DATA)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
